// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= cpuTop.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= === FAIL ===
PASS_MSG  ?= === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF -- "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF -- "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== cpuTop.f ====
rtl/cpuPkg.sv
rtl/programCounter.sv
rtl/instrMemory.sv
rtl/controlUnit.sv
rtl/immGen.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/cpuTop.sv
test/clockGen.sv
test/cpuTop_checker.sv
test/cpuTb.sv

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [cpuPkg::XLen-1:0]  rd1,
    input  logic [cpuPkg::XLen-1:0]  rd2,
    input  logic [cpuPkg::XLen-1:0]  imm,
    input  logic                     aluSrc,
    input  cpuPkg::aluCtrlT          aluCtrl,
    output logic [cpuPkg::XLen-1:0]  result,
    output logic                     eq
);

    // Second operand after source select
    logic [cpuPkg::XLen-1:0] opB;

    // Signed compare for slt and slti
    logic lessThan;

    // Register or immediate operand
    assign opB = aluSrc ? imm : rd2;

    assign lessThan = $signed(rd1) < $signed(opB);

    always_comb begin
        case (aluCtrl)
            cpuPkg::AluAdd: begin
                result = rd1 + opB;
            end
            cpuPkg::AluSub: begin
                result = rd1 - opB;
            end
            cpuPkg::AluAnd: begin
                result = rd1 & opB;
            end
            cpuPkg::AluOr: begin
                result = rd1 | opB;
            end
            // Zero-extended single-bit flag
            cpuPkg::AluSlt: begin
                result = {{(cpuPkg::XLen-1){1'b0}}, lessThan};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Branch condition, same operands as the ALU
    assign eq = (rd1 == opB);

endmodule

// ==== rtl/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit (
    input  cpuPkg::instrT    instr,
    input  logic             eq,
    output logic             regWrite,
    output cpuPkg::aluCtrlT  aluCtrl,
    output logic             aluSrc,
    output cpuPkg::immSrcT   immSrc,
    output logic             pcSrc
);

    always_comb begin
        // No-op defaults, used for unknown encodings
        regWrite = 1'b0;
        aluCtrl  = cpuPkg::AluAdd;
        aluSrc   = 1'b0;
        immSrc   = cpuPkg::ImmI;
        pcSrc    = 1'b0;

        case (instr.r.opcode)
            cpuPkg::OpRType: begin
                regWrite = 1'b1;
                case (instr.r.funct3)
                    // funct7 bit 5 picks sub over add
                    cpuPkg::F3AddSub: begin
                        aluCtrl = instr.r.funct7[5] ? cpuPkg::AluSub : cpuPkg::AluAdd;
                    end
                    cpuPkg::F3Slt: aluCtrl = cpuPkg::AluSlt;
                    cpuPkg::F3Or:  aluCtrl = cpuPkg::AluOr;
                    cpuPkg::F3And: aluCtrl = cpuPkg::AluAnd;
                    // Unsupported R-type ops retire without a write
                    default: regWrite = 1'b0;
                endcase
            end

            cpuPkg::OpIType: begin
                regWrite = 1'b1;
                // Second operand from immediate
                aluSrc   = 1'b1;
                immSrc   = cpuPkg::ImmI;
                case (instr.i.funct3)
                    cpuPkg::F3AddSub: aluCtrl = cpuPkg::AluAdd;
                    cpuPkg::F3Slt:    aluCtrl = cpuPkg::AluSlt;
                    cpuPkg::F3Or:     aluCtrl = cpuPkg::AluOr;
                    cpuPkg::F3And:    aluCtrl = cpuPkg::AluAnd;
                    default:          regWrite = 1'b0;
                endcase
            end

            cpuPkg::OpBranch: begin
                // Compare rs1 against rs2 by subtraction
                aluCtrl = cpuPkg::AluSub;
                immSrc  = cpuPkg::ImmB;
                case (instr.b.funct3)
                    cpuPkg::F3Beq: pcSrc = eq;
                    cpuPkg::F3Bne: pcSrc = !eq;
                    default:       pcSrc = 1'b0;
                endcase
            end

            default: ;
        endcase
    end

endmodule

// ==== rtl/cpuPkg.sv ====
package cpuPkg;

    // Datapath and address width
    localparam int XLen = 32;

    // Register index width, 32 registers
    localparam int RegAddrW = 5;

    // Instruction RAM size in words
    localparam int ImemDepth = 256;
    localparam int ImemAddrW = 8;

    // Major opcodes of the supported subset
    localparam logic [6:0] OpRType  = 7'b0110011;
    localparam logic [6:0] OpIType  = 7'b0010011;
    localparam logic [6:0] OpBranch = 7'b1100011;

    // funct3 for arithmetic and logic
    localparam logic [2:0] F3AddSub = 3'b000;
    localparam logic [2:0] F3Slt    = 3'b010;
    localparam logic [2:0] F3Or     = 3'b110;
    localparam logic [2:0] F3And    = 3'b111;

    // funct3 for branches
    localparam logic [2:0] F3Beq = 3'b000;
    localparam logic [2:0] F3Bne = 3'b001;

    // ALU operation select
    typedef enum logic [2:0] {
        AluAdd = 3'd0,
        AluSub = 3'd1,
        AluAnd = 3'd2,
        AluOr  = 3'd3,
        AluSlt = 3'd4
    } aluCtrlT;

    // Immediate format select
    typedef enum logic {
        ImmI = 1'b0,
        ImmB = 1'b1
    } immSrcT;

    // One instruction word, three decode views
    typedef union packed {
        // Register-register format
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        // Register-immediate format
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        // Branch format, offset split across the word
        struct packed {
            logic        imm12;
            logic [5:0]  imm10to5;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [3:0]  imm4to1;
            logic        imm11;
            logic [6:0]  opcode;
        } b;
    } instrT;

endpackage

// ==== rtl/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          loadEn,
    input  logic [cpuPkg::ImemAddrW-1:0]  loadAddr,
    input  logic [cpuPkg::XLen-1:0]       loadData,
    output logic [cpuPkg::XLen-1:0]       a0
);

    // Fetch
    logic [cpuPkg::XLen-1:0] pc;
    cpuPkg::instrT           instr;

    // Register indices sliced from the instruction
    logic [cpuPkg::RegAddrW-1:0] rs1;
    logic [cpuPkg::RegAddrW-1:0] rs2;
    logic [cpuPkg::RegAddrW-1:0] rd;

    // Operands and results
    logic [cpuPkg::XLen-1:0] rd1;
    logic [cpuPkg::XLen-1:0] rd2;
    logic [cpuPkg::XLen-1:0] imm;
    logic [cpuPkg::XLen-1:0] aluResult;
    logic                    eq;

    // Control
    logic            regWrite;
    logic            aluSrc;
    logic            pcSrc;
    cpuPkg::aluCtrlT aluCtrl;
    cpuPkg::immSrcT  immSrc;

    // Register fields share positions across formats
    assign rs1 = instr.r.rs1;
    assign rs2 = instr.r.rs2;
    assign rd  = instr.r.rd;

    programCounter u_programCounter (
        .clk   (clk),
        .arstN (arstN),
        .pcSrc (pcSrc),
        .imm   (imm),
        .pc    (pc)
    );

    // Program loaded through the strobe port during reset
    instrMemory u_instrMemory (
        .clk      (clk),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .pc       (pc),
        .instr    (instr)
    );

    controlUnit u_controlUnit (
        .instr    (instr),
        .eq       (eq),
        .regWrite (regWrite),
        .aluCtrl  (aluCtrl),
        .aluSrc   (aluSrc),
        .immSrc   (immSrc),
        .pcSrc    (pcSrc)
    );

    immGen u_immGen (
        .instr  (instr),
        .immSrc (immSrc),
        .imm    (imm)
    );

    // ALU result written back in the same cycle
    registerFile u_registerFile (
        .clk   (clk),
        .arstN (arstN),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .wd    (aluResult),
        .we    (regWrite),
        .rd1   (rd1),
        .rd2   (rd2),
        .a0    (a0)
    );

    alu u_alu (
        .rd1     (rd1),
        .rd2     (rd2),
        .imm     (imm),
        .aluSrc  (aluSrc),
        .aluCtrl (aluCtrl),
        .result  (aluResult),
        .eq      (eq)
    );

endmodule

// ==== rtl/immGen.sv ====
`timescale 1ns/1ps

module immGen (
    input  cpuPkg::instrT            instr,
    input  cpuPkg::immSrcT           immSrc,
    output logic [cpuPkg::XLen-1:0]  imm
);

    logic [cpuPkg::XLen-1:0] immI;
    logic [cpuPkg::XLen-1:0] immB;

    // 12-bit immediate, sign from bit 31
    assign immI = {{(cpuPkg::XLen-12){instr.i.imm12[11]}}, instr.i.imm12};

    // Branch offset reassembled, always even
    assign immB = {
        {(cpuPkg::XLen-13){instr.b.imm12}},
        instr.b.imm12,
        instr.b.imm11,
        instr.b.imm10to5,
        instr.b.imm4to1,
        1'b0
    };

    // Format select from decoder
    always_comb begin
        case (immSrc)
            cpuPkg::ImmB: imm = immB;
            default:      imm = immI;
        endcase
    end

endmodule

// ==== rtl/instrMemory.sv ====
`timescale 1ns/1ps

module instrMemory (
    input  logic                          clk,
    input  logic                          loadEn,
    input  logic [cpuPkg::ImemAddrW-1:0]  loadAddr,
    input  logic [cpuPkg::XLen-1:0]       loadData,
    input  logic [cpuPkg::XLen-1:0]       pc,
    output cpuPkg::instrT                 instr
);

    // Program storage, one instruction per word
    logic [cpuPkg::XLen-1:0] mem [cpuPkg::ImemDepth];

    // Word index from byte address
    logic [cpuPkg::ImemAddrW-1:0] fetchIdx;

    // Empty words decode as no-ops
    initial begin
        for (int k = 0; k < cpuPkg::ImemDepth; k++) begin
            mem[k] = '0;
        end
    end

    // Load port, one word per strobe cycle
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
    end

    // Drop byte offset, keep word bits
    assign fetchIdx = pc[cpuPkg::ImemAddrW+1:2];

    // Asynchronous fetch
    assign instr = mem[fetchIdx];

endmodule

// ==== rtl/programCounter.sv ====
`timescale 1ns/1ps

module programCounter (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     pcSrc,
    input  logic [cpuPkg::XLen-1:0]  imm,
    output logic [cpuPkg::XLen-1:0]  pc
);

    logic [cpuPkg::XLen-1:0] pcPlus4;
    logic [cpuPkg::XLen-1:0] pcBranch;
    logic [cpuPkg::XLen-1:0] pcNext;

    // Sequential fetch address
    assign pcPlus4 = pc + cpuPkg::XLen'(4);

    // Branch target, offset already scaled by immGen
    assign pcBranch = pc + imm;

    // Taken branch wins over fall-through
    assign pcNext = pcSrc ? pcBranch : pcPlus4;

    // PC register, restarts at address 0
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic [cpuPkg::RegAddrW-1:0]  rs1,
    input  logic [cpuPkg::RegAddrW-1:0]  rs2,
    input  logic [cpuPkg::RegAddrW-1:0]  rd,
    input  logic [cpuPkg::XLen-1:0]      wd,
    input  logic                         we,
    output logic [cpuPkg::XLen-1:0]      rd1,
    output logic [cpuPkg::XLen-1:0]      rd2,
    output logic [cpuPkg::XLen-1:0]      a0
);

    // x1..x31, x0 has no storage
    logic [cpuPkg::XLen-1:0] regs [1:31];

    // Write on clock edge, x0 target dropped
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wd;
        end
    end

    // Combinational reads, x0 hardwired to zero
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

    // x10 exported for observation
    assign a0 = regs[10];

endmodule

// ==== test/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic clk
);

    // 4 ns period, starts low
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

// ==== test/cpuInput.txt ====
# T <test name> | L <word address, hex> <instruction, hex>
# C <edges after reset release, decimal> <expected a0, hex>
T rtypeOps
L 00 00700093
L 01 ffd00113
L 02 00208533
L 03 40208533
L 04 0020f533
L 05 0020e533
L 06 0020a533
L 07 00112533
C 3 00000004
C 4 0000000a
C 5 00000005
C 6 ffffffff
C 7 00000000
C 8 00000001
T immSignExt
L 00 fff00513
L 01 80050513
L 02 fff57513
L 03 12300513
L 04 ff056513
L 05 ffb52513
L 06 ffb52513
C 1 ffffffff
C 3 fffff7ff
C 5 fffffff3
C 6 00000001
C 7 00000000
T zeroReg
L 00 00500013
L 01 00900093
L 02 00108033
L 03 00100533
L 04 00000533
C 4 00000009
C 5 00000000
T branches
L 00 00300093
L 01 00300113
L 02 00208463
L 03 00100513
L 04 00250513
L 05 00209463
L 06 00450513
C 4 00000002
C 6 00000006
T loopCount
L 00 00500093
L 01 00150513
L 02 fe151ee3
L 03 01050513
C 3 00000001
C 11 00000005
C 12 00000015
T resetRestart
L 00 00150533
L 01 00350513
C 1 00000000
C 2 00000003

// ==== test/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

    logic                         clk;
    logic                         arstN;
    logic                         loadEn;
    logic [cpuPkg::ImemAddrW-1:0] loadAddr;
    logic [cpuPkg::XLen-1:0]      loadData;
    logic [cpuPkg::XLen-1:0]      a0;

    // Parsed stimulus records, kind is T, L or C
    byte         recKind [$];
    string       recName [$];
    logic [31:0] recA [$];
    logic [31:0] recB [$];

    // Hang watchdog state
    int   cycleLimit = 0;
    int   cycleCount = 0;
    bit   limitReady = 1'b0;
    int   checksDone = 0;

    clockGen u_clockGen (
        .clk (clk)
    );

    cpuTop u_cpuTop (
        .clk      (clk),
        .arstN    (arstN),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .a0       (a0)
    );

    task automatic abortRun();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    // One record per line, # lines skipped
    task automatic readStimulus();
        int          fd;
        int          code;
        string       line;
        string       name;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("test/cpuInput.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file test/cpuInput.txt");
            abortRun();
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                name = "";
                a = '0;
                b = '0;
                case (line.getc(0))
                    "T": begin
                        code = $sscanf(line, "T %s", name);
                        // Margin for reset, load and slack
                        cycleLimit += 64;
                    end
                    "L": code = $sscanf(line, "L %h %h", a, b);
                    "C": begin
                        code = $sscanf(line, "C %d %h", a, b);
                        cycleLimit += a;
                    end
                    default: begin
                        $display("unknown record in stimulus file: %s", line);
                        abortRun();
                    end
                endcase
                recKind.push_back(line.getc(0));
                recName.push_back(name);
                recA.push_back(a);
                recB.push_back(b);
            end
        end
        $fclose(fd);
    endtask

    // Single strobe, written at the next rising edge
    task automatic loadWord(input logic [cpuPkg::ImemAddrW-1:0] addr, input cpuPkg::instrT word);
        loadEn   = 1'b1;
        loadAddr = addr;
        loadData = word;
    endtask

    // Reset held 16 cycles, longer if the program needs it
    task automatic resetAndLoad(inout int idx);
        int cyc;
        cyc = 0;
        @(posedge clk);
        #1;
        arstN = 1'b0;
        while (cyc < 16 || (idx < recKind.size() && recKind[idx] == "L")) begin
            if (idx < recKind.size() && recKind[idx] == "L") begin
                loadWord(recA[idx][cpuPkg::ImemAddrW-1:0], recB[idx]);
                idx++;
            end else begin
                loadEn = 1'b0;
            end
            @(posedge clk);
            #1;
            cyc++;
        end
        loadEn = 1'b0;
        arstN  = 1'b1;
    endtask

    task automatic checkWord(input string name, input logic [cpuPkg::XLen-1:0] expected,
                             input logic [cpuPkg::XLen-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch in %s: expected %08h actual %08h", name, expected, actual);
            abortRun();
        end
        checksDone++;
    endtask

    // Watchdog, armed once the limit is known
    initial begin
        wait (limitReady);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("run hung: %0d cycles passed without finishing", cycleLimit);
        abortRun();
    end

    initial begin
        int    idx;
        int    edgesSince;
        string testName;
        arstN    = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        readStimulus();
        limitReady = 1'b1;
        idx = 0;
        while (idx < recKind.size()) begin
            if (recKind[idx] != "T") begin
                $display("stimulus record %0d does not belong to a test", idx);
                abortRun();
            end
            testName = recName[idx];
            idx++;
            resetAndLoad(idx);
            edgesSince = 0;
            // Sample a0 1 ns after the counted edge
            while (idx < recKind.size() && recKind[idx] == "C") begin
                while (edgesSince < recA[idx]) begin
                    @(posedge clk);
                    #1;
                    edgesSince++;
                end
                checkWord(testName, recB[idx], a0);
                idx++;
            end
        end
        if (checksDone == 0) begin
            $display("no checks were found in the stimulus file");
            abortRun();
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// ==== test/cpuTop_checker.sv ====
`timescale 1ns/1ps

module cpuTopChecker (
    input logic                         clk,
    input logic                         arstN,
    input logic [cpuPkg::XLen-1:0]      pc,
    input logic [cpuPkg::RegAddrW-1:0]  rs1,
    input logic [cpuPkg::RegAddrW-1:0]  rs2,
    input logic [cpuPkg::XLen-1:0]      rd1,
    input logic [cpuPkg::XLen-1:0]      imm,
    input logic                         aluSrc,
    input cpuPkg::aluCtrlT              aluCtrl,
    input logic [cpuPkg::XLen-1:0]      aluResult,
    input logic [cpuPkg::XLen-1:0]      a0
);

    // Fetch address on a word boundary
    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("pc %h is not word aligned", pc);

    // First fetch after release comes from address 0
    pcStartsAtZero: assert property (@(posedge clk) $rose(arstN) |-> pc == '0)
        else $error("pc %h after reset release, not 0", pc);

    // x0 as first source, an add passes the immediate through
    x0ReadsZeroA: assert property (@(posedge clk) disable iff (!arstN)
        (rs1 == '0 && aluSrc && aluCtrl == cpuPkg::AluAdd) |-> (aluResult == imm))
        else $error("x0 on port 1 gave sum %h for immediate %h", aluResult, imm);

    // x0 as second source, an add passes rs1 through
    x0ReadsZeroB: assert property (@(posedge clk) disable iff (!arstN)
        (rs2 == '0 && !aluSrc && aluCtrl == cpuPkg::AluAdd) |-> (aluResult == rd1))
        else $error("x0 on port 2 gave sum %h for operand %h", aluResult, rd1);

    // a0 fully defined once out of reset
    a0Known: assert property (@(posedge clk) disable iff (!arstN) !$isunknown(a0))
        else $error("a0 has unknown bits");

endmodule

// Attached at the top, sees PC, register file and ALU wires
bind cpuTop cpuTopChecker u_cpuTopChecker (
    .clk       (clk),
    .arstN     (arstN),
    .pc        (pc),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd1       (rd1),
    .imm       (imm),
    .aluSrc    (aluSrc),
    .aluCtrl   (aluCtrl),
    .aluResult (aluResult),
    .a0        (a0)
);
